// File: sim/core_stim.txt
# cmd arg0 arg1, all values hex
# S left right, U withhold one frame, R addr expected, F addr frame count, B addr blink pair
S A5C3 3C5A
S 8000 0001
S 7FFF FFFE
R 00000000 00000000
S 1234 5678
U
S 0F0F F0F0
S FFFF 8001
B 00100000
R 00100008 00000000
S 4321 8765
F 00100004
R DEADBEEF 00000000
S 9ABC DEF0
U
S C001 00FF
B 00100000
F 00100004
S 5555 AAAA

// File: sim.f
design/core_pkg.sv
design/video_timing.sv
design/video_pattern.sv
design/i2s_serializer.sv
design/bridge_regs.sv
design/core_top.sv
sim/tb_core_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the core_top testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_core_top -f sim.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_core_top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1

// File: sim/tb_core_top.sv
//////////////////////////////
// testbench for core_top
// raster, pattern, i2s and bridge checks
// driven from sim/core_stim.txt
//////////////////////////////

`timescale 1ns/1ns

module tb_core_top import core_pkg::*; ();

    // expected raster and pattern
    localparam int LINE_CLKS   = 400;
    localparam int FRAME_LINES = 512;
    localparam int FRAME_CLKS  = LINE_CLKS * FRAME_LINES;
    localparam int DE_RUNS     = 240;
    localparam int DE_LEN      = 320;
    localparam int SQ_X        = 135;
    localparam int SQ_Y        = 95;
    localparam int SQ_N        = 50;
    localparam logic [7:0] GREY_BG = 8'd60;
    localparam logic [7:0] GREY_SQ = 8'd200;

    logic         clk_core_12288;
    logic         reset_n;
    bridge_addr_t bridge_addr;
    logic         bridge_rd;
    bridge_data_t bridge_rd_data;
    sample_t      sample_left;
    sample_t      sample_right;
    logic         sample_valid;
    logic         sample_ready;
    pixel_t       video_rgb;
    logic         video_de;
    logic         video_hs;
    logic         video_vs;
    logic         audio_sclk;
    logic         audio_lrck;
    logic         audio_dac;

    int seed = 32'h698ce38c;
    int errs[5];
    int checks[5];

    // video monitor state
    int   cyc;
    int   vs_count;
    int   last_vs;
    int   line_no;
    int   hs_in_frame;
    int   de_runs;
    int   run_len;
    logic de_prev;
    logic raster_done;

    // audio monitor state
    sample_t     exp_left_q[$];
    sample_t     exp_right_q[$];
    int          exp_kind_q[$];
    sample_t     cur_right;
    int          cur_kind;
    logic        sclk_prev;
    logic [31:0] slot_bits;
    int          bit_idx;
    int          slot_idx;
    int          real_pushed;
    int          real_checked;
    int          samples_checked;
    int          silent_checked;
    int          samples_sent;
    int          withheld_sent;
    logic        withhold;
    logic        withheld_seen;

    core_top #(
        .BLINK_BIT (6)
    ) dut0 (
        .clk_core_12288 (clk_core_12288),
        .reset_n        (reset_n),
        .bridge_addr    (bridge_addr),
        .bridge_rd      (bridge_rd),
        .bridge_rd_data (bridge_rd_data),
        .sample_left    (sample_left),
        .sample_right   (sample_right),
        .sample_valid   (sample_valid),
        .sample_ready   (sample_ready),
        .video_rgb      (video_rgb),
        .video_de       (video_de),
        .video_hs       (video_hs),
        .video_vs       (video_vs),
        .audio_sclk     (audio_sclk),
        .audio_lrck     (audio_lrck),
        .audio_dac      (audio_dac)
    );

    initial begin
        clk_core_12288 = 1'b0;
        forever #2 clk_core_12288 = ~clk_core_12288;
    end

    //////////////////////////////
    // compare and report
    //////////////////////////////
    task automatic check_pixel(input int id, input string what, input pixel_t got,
                               input pixel_t exp);
        checks[id]++;
        if (got !== exp) begin
            errs[id]++;
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_sample(input int id, input string what, input sample_t got,
                                input sample_t exp);
        checks[id]++;
        if (got !== exp) begin
            errs[id]++;
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bridge(input int id, input string what, input bridge_data_t got,
                                input bridge_data_t exp);
        checks[id]++;
        if (got !== exp) begin
            errs[id]++;
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int id, input string what, input int got, input int exp);
        checks[id]++;
        if (got != exp) begin
            errs[id]++;
            $display("Mismatch at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic fail_note(input int id, input string msg);
        checks[id]++;
        errs[id]++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    function automatic string test_label(input int id);
        case (id)
            0:       return "raster counts";
            1:       return "test pattern";
            2:       return "audio data";
            3:       return "audio underrun";
            default: return "bridge read-back";
        endcase
    endfunction

    task automatic report_test(input int id);
        $display("test %s: %s, %0d checks, %0d errors", test_label(id),
                 (errs[id] == 0) ? "ok" : "failed", checks[id], errs[id]);
    endtask

    //////////////////////////////
    // monitors, sampled at negedge
    //////////////////////////////
    function automatic pixel_t expected_pixel(input int col, input int row);
        if (col >= SQ_X && col < SQ_X + SQ_N && row >= SQ_Y && row < SQ_Y + SQ_N) begin
            return {3{GREY_SQ}};
        end
        return {3{GREY_BG}};
    endfunction

    task automatic watch_video();
        if (video_vs) begin
            if (vs_count == 0) begin
                check_count(0, "video_vs first cycle", cyc, 2);
            end else begin
                check_count(0, "video_vs period", cyc - last_vs, FRAME_CLKS);
            end
            // second vs closes the one frame that is fully checked
            if (vs_count == 1) begin
                check_count(0, "video_hs pulses", hs_in_frame, FRAME_LINES);
                check_count(0, "video_de runs", de_runs, DE_RUNS);
                raster_done = 1'b1;
                report_test(0);
                report_test(1);
            end
            vs_count++;
            last_vs = cyc;
            line_no = 0;
        end
        if (video_hs) begin
            line_no++;
        end
        if (vs_count == 1) begin
            if (video_hs) begin
                hs_in_frame++;
            end
            if (video_de) begin
                check_pixel(1, "video_rgb", video_rgb, expected_pixel(run_len, de_runs));
                run_len++;
            end else begin
                check_pixel(1, "video_rgb", video_rgb, '0);
                if (de_prev) begin
                    check_count(0, "video_de run length", run_len, DE_LEN);
                    de_runs++;
                    run_len = 0;
                end
            end
        end
        de_prev = video_de;
    endtask

    task automatic push_expected(input sample_t left, input sample_t right, input int kind);
        exp_left_q.push_back(left);
        exp_right_q.push_back(right);
        exp_kind_q.push_back(kind);
    endtask

    // kind 0 idle zeros, 1 file sample, 2 withheld on purpose
    task automatic watch_handshake();
        if (sample_ready && sample_valid) begin
            push_expected(sample_left, sample_right, 1);
            real_pushed++;
        end else if (sample_ready) begin
            push_expected('0, '0, withhold ? 2 : 0);
            if (withhold) begin
                real_pushed++;
                withheld_seen = 1'b1;
            end
        end
    endtask

    task automatic finish_slot();
        sample_t want;
        int      id;
        if (slot_idx % 2 == 0) begin
            if (exp_left_q.size() == 0) begin
                fail_note(2, "audio left slot with nothing queued");
                want      = '0;
                cur_right = '0;
                cur_kind  = 0;
            end else begin
                want      = exp_left_q.pop_front();
                cur_right = exp_right_q.pop_front();
                cur_kind  = exp_kind_q.pop_front();
            end
        end else begin
            want = cur_right;
        end
        id = (cur_kind == 2) ? 3 : 2;
        check_sample(id, "audio_dac sample bits", slot_bits[31:16], want);
        check_sample(id, "audio_dac tail bits", slot_bits[15:0], '0);
        if (slot_idx % 2 == 1) begin
            if (cur_kind != 0) begin
                real_checked++;
            end
            if (cur_kind == 1) begin
                samples_checked++;
            end
            if (cur_kind == 2) begin
                silent_checked++;
            end
        end
    endtask

    // dac bits taken at rising sclk, 32 per slot, left slot first
    task automatic watch_audio();
        if (audio_sclk && !sclk_prev) begin
            check_count(2, "audio_lrck", int'(audio_lrck), slot_idx % 2);
            slot_bits = {slot_bits[30:0], audio_dac};
            bit_idx++;
            if (bit_idx == 32) begin
                finish_slot();
                bit_idx = 0;
                slot_idx++;
            end
        end
        sclk_prev = audio_sclk;
    endtask

    always @(negedge clk_core_12288) begin
        if (reset_n) begin
            watch_video();
            watch_handshake();
            watch_audio();
            cyc++;
        end
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////
    task automatic send_sample(input sample_t left, input sample_t right);
        int gap;
        int waited;
        gap = $unsigned($random(seed)) % 40;
        waited = 0;
        repeat (gap) @(posedge clk_core_12288);
        @(posedge clk_core_12288);
        sample_left  <= left;
        sample_right <= right;
        sample_valid <= 1'b1;
        @(negedge clk_core_12288);
        while (!sample_ready && waited < 1024) begin
            @(negedge clk_core_12288);
            waited++;
        end
        if (!sample_ready) begin
            fail_note(2, "sample_ready never came for a waiting sample");
        end
        // transfer edge
        @(posedge clk_core_12288);
        sample_valid <= 1'b0;
    endtask

    task automatic withhold_frame();
        int waited;
        waited = 0;
        withheld_seen = 1'b0;
        withhold = 1'b1;
        while (!withheld_seen && waited < 1024) begin
            @(negedge clk_core_12288);
            waited++;
        end
        withhold = 1'b0;
        if (!withheld_seen) begin
            fail_note(3, "no sample_ready while valid was withheld");
        end
    endtask

    task automatic bridge_read(input bridge_addr_t addr, output bridge_data_t data);
        @(posedge clk_core_12288);
        bridge_addr <= addr;
        bridge_rd   <= 1'b1;
        @(posedge clk_core_12288);
        bridge_rd   <= 1'b0;
        @(negedge clk_core_12288);
        data = bridge_rd_data;
    endtask

    task automatic frame_read(input bridge_addr_t addr);
        bridge_data_t rd;
        int           waited;
        waited = 0;
        // middle of the frame, well away from the counter update
        while (line_no != FRAME_LINES / 2 && waited < 2 * FRAME_CLKS) begin
            @(negedge clk_core_12288);
            waited++;
        end
        if (line_no != FRAME_LINES / 2) begin
            fail_note(4, "video never reached the middle of a frame");
        end
        bridge_read(addr, rd);
        check_bridge(4, "bridge_rd_data frame", rd, bridge_data_t'(frame_cnt_t'(vs_count)));
    endtask

    task automatic blink_pair(input bridge_addr_t addr);
        bridge_data_t rd_a;
        bridge_data_t rd_b;
        bridge_read(addr, rd_a);
        // second read strobe lands 64 clocks after the first
        repeat (62) @(posedge clk_core_12288);
        bridge_read(addr, rd_b);
        check_bridge(4, "bridge_rd_data blink", rd_a & 32'hffff_fffe, '0);
        check_bridge(4, "bridge_rd_data blink", rd_b & 32'hffff_fffe, '0);
        if (rd_a[0] == rd_b[0]) begin
            fail_note(4, "blink bit did not toggle over 64 clocks");
        end
    endtask

    task automatic run_command(input int fd, input logic [7:0] cmd);
        logic [31:0]    arg0;
        logic [31:0]    arg1;
        bridge_data_t   rd;
        logic [1023:0]  line_buf;
        int             code;
        case (cmd)
            "#": code = $fgets(line_buf, fd);
            "S": begin
                code = $fscanf(fd, "%h %h", arg0, arg1);
                send_sample(arg0[15:0], arg1[15:0]);
                samples_sent++;
            end
            "U": begin
                withhold_frame();
                withheld_sent++;
            end
            "R": begin
                code = $fscanf(fd, "%h %h", arg0, arg1);
                bridge_read(arg0, rd);
                check_bridge(4, "bridge_rd_data", rd, arg1);
            end
            "F": begin
                code = $fscanf(fd, "%h", arg0);
                frame_read(arg0);
            end
            "B": begin
                code = $fscanf(fd, "%h", arg0);
                blink_pair(arg0);
            end
            default: fail_note(4, "unknown command in the stimulus file");
        endcase
    endtask

    initial begin
        int   fd;
        int   code;
        int   waited;
        int   total_checks;
        int   total_errs;
        int   failed;
        logic [7:0] cmd;
        logic done;
        bridge_addr  = '0;
        bridge_rd    = 1'b0;
        sample_left  = '0;
        sample_right = '0;
        sample_valid = 1'b0;
        withhold     = 1'b0;
        raster_done  = 1'b0;
        reset_n      = 1'b0;
        // frame from reset state, then the empty holding register
        push_expected('0, '0, 0);
        push_expected('0, '0, 0);
        repeat (2) @(posedge clk_core_12288);
        reset_n <= 1'b1;

        fd = $fopen("sim/core_stim.txt", "r");
        if (fd == 0) begin
            fail_note(4, "cannot open sim/core_stim.txt");
        end else begin
            done = 1'b0;
            while (!done) begin
                code = $fscanf(fd, "%s", cmd);
                if (code != 1) begin
                    done = 1'b1;
                end else begin
                    run_command(fd, cmd);
                end
            end
            $fclose(fd);
        end
        report_test(4);

        // drain the serializer and finish the checked frame
        waited = 0;
        while ((real_checked != real_pushed || !raster_done) && waited < 3 * FRAME_CLKS) begin
            @(negedge clk_core_12288);
            waited++;
        end
        if (!raster_done) begin
            fail_note(0, "timed out before a full video frame was seen");
            report_test(0);
            report_test(1);
        end
        if (real_checked != real_pushed) begin
            fail_note(2, "timed out with audio frames still queued");
        end
        check_count(2, "audio samples out", samples_checked, samples_sent);
        check_count(3, "silent audio frames", silent_checked, withheld_sent);
        report_test(2);
        report_test(3);

        total_checks = 0;
        total_errs   = 0;
        failed       = 0;
        for (int i = 0; i < 5; i++) begin
            total_checks += checks[i];
            total_errs   += errs[i];
            if (errs[i] != 0) begin
                failed++;
            end
        end
        $display("tests 5, failed %0d, checks %0d, errors %0d", failed, total_checks, total_errs);
        if (total_errs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: design/core_top.sv
//////////////////////////////
// core top level
// video pattern, i2s audio and bridge read-back
// in the core clock domain
//////////////////////////////

`timescale 1ns/1ns

module core_top import core_pkg::*; #(
    parameter int H_TOTAL   = DEF_H_TOTAL,
    parameter int H_ACTIVE  = DEF_H_ACTIVE,
    parameter int H_BPORCH  = DEF_H_BPORCH,
    parameter int V_TOTAL   = DEF_V_TOTAL,
    parameter int V_ACTIVE  = DEF_V_ACTIVE,
    parameter int V_BPORCH  = DEF_V_BPORCH,
    parameter int BLINK_BIT = DEF_BLINK_BIT
) (
    input  logic         clk_core_12288,
    input  logic         reset_n,
    // bridge
    input  bridge_addr_t bridge_addr,
    input  logic         bridge_rd,
    output bridge_data_t bridge_rd_data,
    // audio samples
    input  sample_t      sample_left,
    input  sample_t      sample_right,
    input  logic         sample_valid,
    output logic         sample_ready,
    // video
    output pixel_t       video_rgb,
    output logic         video_de,
    output logic         video_hs,
    output logic         video_vs,
    // audio i2s
    output logic         audio_sclk,
    output logic         audio_lrck,
    output logic         audio_dac
);

    logic       line_start;
    logic       frame_start;
    logic       active;
    coord_t     visible_x;
    coord_t     visible_y;
    frame_cnt_t frame_count;

    //////////////////////////////
    // video chain
    //////////////////////////////
    video_timing #(
        .H_TOTAL  (H_TOTAL),
        .H_ACTIVE (H_ACTIVE),
        .H_BPORCH (H_BPORCH),
        .V_TOTAL  (V_TOTAL),
        .V_ACTIVE (V_ACTIVE),
        .V_BPORCH (V_BPORCH)
    ) u_video_timing (
        .clk_core_12288 (clk_core_12288),
        .reset_n        (reset_n),
        .line_start     (line_start),
        .frame_start    (frame_start),
        .active         (active),
        .visible_x      (visible_x),
        .visible_y      (visible_y),
        .frame_count    (frame_count)
    );

    video_pattern u_video_pattern (
        .clk_core_12288 (clk_core_12288),
        .reset_n        (reset_n),
        .line_start     (line_start),
        .frame_start    (frame_start),
        .active         (active),
        .visible_x      (visible_x),
        .visible_y      (visible_y),
        .video_rgb      (video_rgb),
        .video_de       (video_de),
        .video_hs       (video_hs),
        .video_vs       (video_vs)
    );

    //////////////////////////////
    // audio and bridge
    //////////////////////////////
    i2s_serializer u_i2s_serializer (
        .clk_core_12288 (clk_core_12288),
        .reset_n        (reset_n),
        .sample_left    (sample_left),
        .sample_right   (sample_right),
        .sample_valid   (sample_valid),
        .sample_ready   (sample_ready),
        .audio_sclk     (audio_sclk),
        .audio_lrck     (audio_lrck),
        .audio_dac      (audio_dac)
    );

    bridge_regs #(
        .BLINK_BIT (BLINK_BIT)
    ) u_bridge_regs (
        .clk_core_12288 (clk_core_12288),
        .reset_n        (reset_n),
        .bridge_addr    (bridge_addr),
        .bridge_rd      (bridge_rd),
        .frame_count    (frame_count),
        .bridge_rd_data (bridge_rd_data)
    );

endmodule

// File: design/bridge_regs.sv
//////////////////////////////
// bridge read-back
// free-running blink counter and registered read mux
//////////////////////////////

`timescale 1ns/1ns

module bridge_regs import core_pkg::*; #(
    parameter int BLINK_BIT = DEF_BLINK_BIT
) (
    input  logic         clk_core_12288,
    input  logic         reset_n,
    input  bridge_addr_t bridge_addr,
    input  logic         bridge_rd,
    input  frame_cnt_t   frame_count,
    output bridge_data_t bridge_rd_data
);

    logic [31:0]  blink_cnt;
    bridge_data_t rd_mux;

    // address decode, unmapped reads as zero
    always_comb begin
        case (bridge_addr)
            ADDR_BLINK: rd_mux = bridge_data_t'(blink_cnt[BLINK_BIT]);
            ADDR_FRAME: rd_mux = bridge_data_t'(frame_count);
            default:    rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk_core_12288 or negedge reset_n) begin
        if (!reset_n) begin
            blink_cnt      <= '0;
            bridge_rd_data <= '0;
        end else begin
            blink_cnt <= blink_cnt + 1'b1;
            // data held until the next read strobe
            if (bridge_rd) begin
                bridge_rd_data <= rd_mux;
            end
        end
    end

endmodule

// File: design/i2s_serializer.sv
//////////////////////////////
// i2s serializer
// sclk at clock / 4, 32 bit slots, 16 bit samples
// msb first, taken by a valid/ready handshake
//////////////////////////////

`timescale 1ns/1ns

module i2s_serializer import core_pkg::*; (
    input  logic    clk_core_12288,
    input  logic    reset_n,
    input  sample_t sample_left,
    input  sample_t sample_right,
    input  logic    sample_valid,
    output logic    sample_ready,
    output logic    audio_sclk,
    output logic    audio_lrck,
    output logic    audio_dac
);

    logic [1:0] clk_div;
    logic [4:0] bit_cnt;
    logic       sclk_fall;
    logic       slot_end;
    sample_t    pend_left;
    sample_t    pend_right;
    sample_t    cur_right;
    sample_t    shift_reg;

    // sclk low for div 0..1, high for 2..3
    assign audio_sclk = clk_div[1];
    // edge where sclk drops back low
    assign sclk_fall  = (clk_div == 2'd3);
    assign slot_end   = sclk_fall && (bit_cnt == 5'd31);
    // offered once per frame, as the right slot ends
    assign sample_ready = slot_end && audio_lrck;

    //////////////////////////////
    // divider and slot counter
    //////////////////////////////
    always_ff @(posedge clk_core_12288 or negedge reset_n) begin
        if (!reset_n) begin
            clk_div    <= '0;
            bit_cnt    <= '0;
            audio_lrck <= 1'b0;
        end else begin
            clk_div <= clk_div + 1'b1;
            if (sclk_fall) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            if (slot_end) begin
                audio_lrck <= ~audio_lrck;
            end
        end
    end

    //////////////////////////////
    // sample capture and shift
    //////////////////////////////
    always_ff @(posedge clk_core_12288 or negedge reset_n) begin
        if (!reset_n) begin
            pend_left  <= '0;
            pend_right <= '0;
            cur_right  <= '0;
            shift_reg  <= '0;
            audio_dac  <= 1'b0;
        end else begin
            // no valid at the boundary means a silent frame
            if (sample_ready) begin
                pend_left  <= sample_valid ? sample_left  : '0;
                pend_right <= sample_valid ? sample_right : '0;
            end
            if (slot_end && audio_lrck) begin
                // new left slot, previous pair goes out now
                audio_dac <= pend_left[15];
                shift_reg <= {pend_left[14:0], 1'b0};
                cur_right <= pend_right;
            end else if (slot_end) begin
                // right slot of the same pair
                audio_dac <= cur_right[15];
                shift_reg <= {cur_right[14:0], 1'b0};
            end else if (sclk_fall) begin
                // zeros fill in after the 16th bit
                audio_dac <= shift_reg[15];
                shift_reg <= {shift_reg[14:0], 1'b0};
            end
        end
    end

    a_ready_pulse: assert property (@(posedge clk_core_12288) disable iff (!reset_n)
        sample_ready |=> !sample_ready)
        else $error("sample_ready held for two cycles");

endmodule

// File: design/video_pattern.sv
//////////////////////////////
// test pattern generator
// grey field with a lighter square, colour,
// data enable and syncs registered together
//////////////////////////////

`timescale 1ns/1ns

module video_pattern import core_pkg::*; (
    input  logic   clk_core_12288,
    input  logic   reset_n,
    input  logic   line_start,
    input  logic   frame_start,
    input  logic   active,
    input  coord_t visible_x,
    input  coord_t visible_y,
    output pixel_t video_rgb,
    output logic   video_de,
    output logic   video_hs,
    output logic   video_vs
);

    logic   in_square;
    pixel_t pixel_next;

    // square bounds, half open on the far edge
    assign in_square = (visible_x >= coord_t'(SQUARE_X)) &&
                       (visible_x <  coord_t'(SQUARE_X + SQUARE_SIZE)) &&
                       (visible_y >= coord_t'(SQUARE_Y)) &&
                       (visible_y <  coord_t'(SQUARE_Y + SQUARE_SIZE));

    // black outside the active area
    always_comb begin
        pixel_next = '0;
        if (active) begin
            pixel_next = in_square ? {3{SQUARE_LEVEL}} : {3{BG_LEVEL}};
        end
    end

    always_ff @(posedge clk_core_12288 or negedge reset_n) begin
        if (!reset_n) begin
            video_rgb <= '0;
            video_de  <= 1'b0;
            video_hs  <= 1'b0;
            video_vs  <= 1'b0;
        end else begin
            video_rgb <= pixel_next;
            video_de  <= active;
            video_hs  <= line_start;
            video_vs  <= frame_start;
        end
    end

endmodule

// File: design/video_timing.sv
//////////////////////////////
// video raster timing
// line and frame counters, sync pulses, active window,
// visible coordinates and frame count
//////////////////////////////

`timescale 1ns/1ns

module video_timing import core_pkg::*; #(
    parameter int H_TOTAL  = DEF_H_TOTAL,
    parameter int H_ACTIVE = DEF_H_ACTIVE,
    parameter int H_BPORCH = DEF_H_BPORCH,
    parameter int V_TOTAL  = DEF_V_TOTAL,
    parameter int V_ACTIVE = DEF_V_ACTIVE,
    parameter int V_BPORCH = DEF_V_BPORCH
) (
    input  logic       clk_core_12288,
    input  logic       reset_n,
    output logic       line_start,
    output logic       frame_start,
    output logic       active,
    output coord_t     visible_x,
    output coord_t     visible_y,
    output frame_cnt_t frame_count
);

    coord_t x_count;
    coord_t y_count;
    logic   x_in_window;
    logic   y_in_window;

    // window decode on the raw counters
    assign x_in_window = (x_count >= coord_t'(H_BPORCH)) &&
                         (x_count <  coord_t'(H_BPORCH + H_ACTIVE));
    assign y_in_window = (y_count >= coord_t'(V_BPORCH)) &&
                         (y_count <  coord_t'(V_BPORCH + V_ACTIVE));

    always_ff @(posedge clk_core_12288 or negedge reset_n) begin
        if (!reset_n) begin
            x_count     <= '0;
            y_count     <= '0;
            line_start  <= 1'b0;
            frame_start <= 1'b0;
            active      <= 1'b0;
            visible_x   <= '0;
            visible_y   <= '0;
            frame_count <= '0;
        end else begin
            // x wraps at line end, y at frame end
            if (x_count == coord_t'(H_TOTAL - 1)) begin
                x_count <= '0;
                if (y_count == coord_t'(V_TOTAL - 1)) begin
                    y_count <= '0;
                end else begin
                    y_count <= y_count + 1'b1;
                end
            end else begin
                x_count <= x_count + 1'b1;
            end

            // registered decode, one cycle behind the counters
            frame_start <= (x_count == '0) && (y_count == '0);
            line_start  <= (x_count == coord_t'(HS_POS));
            active      <= x_in_window && y_in_window;
            // porch removed, wraps harmlessly outside the window
            visible_x   <= x_count - coord_t'(H_BPORCH);
            visible_y   <= y_count - coord_t'(V_BPORCH);

            if ((x_count == '0) && (y_count == '0)) begin
                frame_count <= frame_count + 1'b1;
            end
        end
    end

    // active only with visible coordinates inside the active area
    a_active_window: assert property (@(posedge clk_core_12288) disable iff (!reset_n)
        active |-> ((visible_x < coord_t'(H_ACTIVE)) && (visible_y < coord_t'(V_ACTIVE))))
        else $error("active outside the H_ACTIVE x V_ACTIVE window");

endmodule

// File: design/core_pkg.sv
//////////////////////////////
// core package
// shared widths, payload types, raster defaults,
// test pattern geometry and bridge register map
//////////////////////////////

package core_pkg;

    // payload types
    typedef logic [9:0]  coord_t;
    typedef logic [23:0] pixel_t;
    typedef logic [15:0] sample_t;
    typedef logic [15:0] frame_cnt_t;
    typedef logic [31:0] bridge_addr_t;
    typedef logic [31:0] bridge_data_t;

    // default raster, 400 x 512 clocks per frame
    localparam int DEF_H_TOTAL  = 400;
    localparam int DEF_H_ACTIVE = 320;
    localparam int DEF_H_BPORCH = 10;
    localparam int DEF_V_TOTAL  = 512;
    localparam int DEF_V_ACTIVE = 240;
    localparam int DEF_V_BPORCH = 10;
    // hs a few clocks after vs, never on the same cycle
    localparam int HS_POS       = 3;

    // grey levels and square placement
    localparam logic [7:0] BG_LEVEL     = 8'd60;
    localparam logic [7:0] SQUARE_LEVEL = 8'd200;
    localparam int SQUARE_X    = 135;
    localparam int SQUARE_Y    = 95;
    localparam int SQUARE_SIZE = 50;

    // bridge read map
    localparam bridge_addr_t ADDR_BLINK = 32'h0010_0000;
    localparam bridge_addr_t ADDR_FRAME = 32'h0010_0004;
    localparam int DEF_BLINK_BIT = 24;

endpackage
